// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int unsigned XLEN        = 32;
    localparam int unsigned REG_ADDR_W  = 5;
    localparam int unsigned IMEM_DEPTH  = 256;
    localparam int unsigned IMEM_ADDR_W = 8;
    localparam int unsigned DMEM_DEPTH  = 256;
    localparam int unsigned DMEM_ADDR_W = 8;

    // base opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'h33;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_LOAD   = 7'h03;
    localparam logic [6:0] OP_STORE  = 7'h23;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_AUIPC  = 7'h17;
    localparam logic [6:0] OP_JAL    = 7'h6f;

    localparam logic [2:0] F3_ADD_SUB = 3'h0;
    localparam logic [2:0] F3_SLL     = 3'h1;
    localparam logic [2:0] F3_SLT     = 3'h2;
    localparam logic [2:0] F3_SLTU    = 3'h3;
    localparam logic [2:0] F3_XOR     = 3'h4;
    localparam logic [2:0] F3_SRL_SRA = 3'h5;
    localparam logic [2:0] F3_OR      = 3'h6;
    localparam logic [2:0] F3_AND     = 3'h7;
    localparam logic [2:0] F3_BEQ     = 3'h0; // branch funct3
    localparam logic [2:0] F3_BNE     = 3'h1;

    typedef enum logic [3:0] {
        ALU_AND    = 4'h0,
        ALU_OR     = 4'h1,
        ALU_ADD    = 4'h2,
        ALU_SUB    = 4'h6,
        ALU_XOR    = 4'h7,
        ALU_SLL    = 4'h8,
        ALU_SLT    = 4'h9,
        ALU_SLTU   = 4'ha,
        ALU_SRL    = 4'hb,
        ALU_SRA    = 4'hc,
        ALU_PASS_B = 4'hd  // lui
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2      // link address for jal
    } wb_sel_t;

endpackage

`default_nettype wire

// ==== src/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  alu_op_t              alu_op,
    input  wire logic [XLEN-1:0] a,
    input  wire logic [XLEN-1:0] b,
    output logic      [XLEN-1:0] result,
    output logic                 zero
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_AND:
                result = a & b;
            ALU_OR:
                result = a | b;
            ALU_ADD:
                result = a + b;
            ALU_SUB:
                result = a - b;
            ALU_XOR:
                result = a ^ b;
            ALU_SLL:
                result = a << shamt;
            ALU_SLT:
                result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SRL:
                result = a >> shamt;
            ALU_SRA:
                result = $unsigned($signed(a) >>> shamt); // sign fills from the top
            ALU_PASS_B:
                result = b;
            default:
                result = a & b;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== src/rv_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen import rv_pkg::*; (
    input  wire logic [XLEN-1:0] instr,
    output logic      [XLEN-1:0] imm
);

    logic [6:0] opcode;
    logic       sign;

    assign opcode = instr[6:0];
    assign sign   = instr[31];

    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD:
                imm = {{20{sign}}, instr[31:20]};
            OP_STORE:
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            OP_BRANCH: // offset in halfwords
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {instr[31:12], 12'b0};
            OP_JAL:
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0; // R-type has no immediate
        endcase
    end

endmodule

`default_nettype wire

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
    input  wire logic [XLEN-1:0] instr,
    output alu_op_t              alu_op,
    output logic                 alu_src_imm,
    output logic                 a_src_pc,
    output logic                 reg_we,
    output logic                 mem_we,
    output wb_sel_t              wb_sel,
    output logic                 branch,
    output logic                 branch_ne,
    output logic                 jump,
    output logic                 illegal
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic                  funct7_b5;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_write; // write intent before the x0 check

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rd        = instr[11:7];

    // shared by register and immediate ALU forms
    function automatic alu_op_t f3_to_alu(input logic [2:0] f3, input logic sub_en,
                                          input logic sra_en);
        case (f3)
            F3_ADD_SUB: return sub_en ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return sra_en ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        a_src_pc    = 1'b0;
        rd_write    = 1'b0;
        mem_we      = 1'b0;
        wb_sel      = WB_ALU;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        jump        = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            OP_R: begin
                alu_op   = f3_to_alu(funct3, funct7_b5, funct7_b5);
                rd_write = 1'b1;
            end
            OP_IMM: begin
                alu_op      = f3_to_alu(funct3, 1'b0, funct7_b5); // no subi
                alu_src_imm = 1'b1;
                rd_write    = 1'b1;
            end
            OP_LOAD: begin
                alu_src_imm = 1'b1; // rs1 + offset
                rd_write    = 1'b1;
                wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                alu_src_imm = 1'b1;
                mem_we      = 1'b1;
            end
            OP_BRANCH: begin
                alu_op    = ALU_SUB; // zero flag gives equality
                branch    = 1'b1;
                branch_ne = (funct3 == F3_BNE);
            end
            OP_LUI: begin
                alu_op      = ALU_PASS_B;
                alu_src_imm = 1'b1;
                rd_write    = 1'b1;
            end
            OP_AUIPC: begin
                alu_src_imm = 1'b1;
                a_src_pc    = 1'b1;
                rd_write    = 1'b1;
            end
            OP_JAL: begin
                jump     = 1'b1;
                rd_write = 1'b1;
                wb_sel   = WB_PC4;
            end
            default: illegal = 1'b1; // retires as a no-op
        endcase
    end

    assign reg_we = rd_write && (rd != '0);

endmodule

`default_nettype wire

// ==== src/rv_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file import rv_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  we,
    input  wire logic [REG_ADDR_W-1:0] rd,
    input  wire logic [XLEN-1:0]       wd,
    input  wire logic [REG_ADDR_W-1:0] rs1,
    input  wire logic [REG_ADDR_W-1:0] rs2,
    output logic      [XLEN-1:0]       rd1,
    output logic      [XLEN-1:0]       rd2
);

    logic [XLEN-1:0] regs [1 << REG_ADDR_W]; // entry 0 is x0, cleared in reset

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs[0] <= '0;
        end else if (we && (rd != '0)) begin // x0 is never overwritten
            regs[rd] <= wd;
        end
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (rd1 == '0))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// ==== src/rv_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_data_mem import rv_pkg::*; (
    input  wire logic            clk,
    input  wire logic            we,
    input  wire logic [XLEN-1:0] addr,
    input  wire logic [XLEN-1:0] wd,
    output logic      [XLEN-1:0] rd
);

    logic [XLEN-1:0]        mem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] word_idx;

    assign word_idx = addr[DMEM_ADDR_W+1:2]; // byte address to word
    assign rd       = mem[word_idx];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_idx] <= wd;
        end
    end

    // only whole aligned words are stored
    a_aligned_store: assert property (@(posedge clk) we |-> (addr[1:0] == 2'b00))
        else $error("misaligned store to 0x%08h", addr);

endmodule

`default_nettype wire

// ==== src/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   run,
    input  wire logic                   load_en,
    input  wire logic [IMEM_ADDR_W-1:0] load_addr,
    input  wire logic [XLEN-1:0]        load_data,
    input  wire logic                   branch,
    input  wire logic                   branch_ne,
    input  wire logic                   jump,
    input  wire logic                   zero,
    input  wire logic [XLEN-1:0]        imm,
    output logic      [XLEN-1:0]        pc,
    output logic      [XLEN-1:0]        instr
);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic            take;    // redirect to pc + imm
    logic [XLEN-1:0] pc_next;

    assign instr = imem[pc[IMEM_ADDR_W+1:2]];

    // zero is set when rs1 == rs2, bne inverts the test
    assign take    = jump || (branch && (zero != branch_ne));
    assign pc_next = take ? pc + imm : pc + XLEN'(4);

    always_ff @(posedge clk) begin
        if (load_en && !run) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    a_no_load_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_en && run))
        else $error("program load attempted while running");

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   run,
    input  wire logic                   load_en,
    input  wire logic [IMEM_ADDR_W-1:0] load_addr,
    input  wire logic [XLEN-1:0]        load_data,
    output logic                        retire_valid,
    output logic      [XLEN-1:0]        retire_pc,
    output logic      [REG_ADDR_W-1:0]  retire_rd,
    output logic                        retire_we,
    output logic      [XLEN-1:0]        retire_data,
    output logic                        retire_illegal
);

    logic [XLEN-1:0] pc, instr, imm, rd1, rd2, alu_a, alu_b, alu_result, mem_rd;
    logic [XLEN-1:0] wb_data;
    alu_op_t         alu_op;
    wb_sel_t         wb_sel;
    logic            alu_src_imm, a_src_pc, reg_we, mem_we, branch, branch_ne, jump;
    logic            illegal, zero;

    assign alu_a = a_src_pc ? pc : rd1;     // auipc uses pc
    assign alu_b = alu_src_imm ? imm : rd2;

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = mem_rd;
            WB_PC4:  wb_data = pc + XLEN'(4);
            default: wb_data = alu_result;
        endcase
    end

    rv_fetch i_fetch (
        .clk(clk), .rst_n(rst_n), .run(run), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .branch(branch), .branch_ne(branch_ne), .jump(jump),
        .zero(zero), .imm(imm), .pc(pc), .instr(instr)
    );

    rv_decoder i_decoder (
        .instr(instr), .alu_op(alu_op), .alu_src_imm(alu_src_imm), .a_src_pc(a_src_pc),
        .reg_we(reg_we), .mem_we(mem_we), .wb_sel(wb_sel), .branch(branch),
        .branch_ne(branch_ne), .jump(jump), .illegal(illegal)
    );

    rv_imm_gen i_imm_gen (.instr(instr), .imm(imm));

    rv_reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n), .we(reg_we && run), .rd(instr[11:7]), .wd(wb_data),
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd1(rd1), .rd2(rd2)
    );

    rv_alu i_alu (.alu_op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .zero(zero));

    rv_data_mem i_data_mem (
        .clk(clk), .we(mem_we && run), .addr(alu_result), .wd(rd2), .rd(mem_rd)
    );

    // one record per running cycle
    assign retire_valid   = run;
    assign retire_pc      = pc;
    assign retire_rd      = instr[11:7];
    assign retire_we      = reg_we && run;
    assign retire_data    = wb_data;
    assign retire_illegal = illegal;

endmodule

`default_nettype wire

// ==== tb/rv_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_checker import rv_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  retire_valid,
    input  wire logic [XLEN-1:0]       retire_pc,
    input  wire logic [REG_ADDR_W-1:0] retire_rd,
    input  wire logic                  retire_we,
    input  wire logic [XLEN-1:0]       retire_data,
    input  wire logic                  retire_illegal,
    input  wire logic [127:0]          exp_name,
    input  wire logic [XLEN-1:0]       exp_pc,
    input  wire logic [REG_ADDR_W-1:0] exp_rd,
    input  wire logic                  exp_we,
    input  wire logic [XLEN-1:0]       exp_data,
    input  wire logic                  exp_illegal,
    input  wire logic [31:0]           num_rec,
    output int                         checked,
    output int                         errors,
    output logic                       done
);

    int bad; // mismatches in the current record

    function automatic int check_field(input logic [127:0] test, input string field,
                                       input logic [XLEN-1:0] expected,
                                       input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %0s %s: expected 0x%08h, actual 0x%08h",
                     test, field, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            checked <= 0;
            errors  <= 0;
            done    <= 1'b0;
        end else if (retire_valid && !done) begin
            bad = check_field(exp_name, "pc", exp_pc, retire_pc);
            bad += check_field(exp_name, "we", XLEN'(exp_we), XLEN'(retire_we));
            bad += check_field(exp_name, "illegal", XLEN'(exp_illegal), XLEN'(retire_illegal));
            if (exp_we) begin // rd and data only mean something on a write
                bad += check_field(exp_name, "rd", XLEN'(exp_rd), XLEN'(retire_rd));
                bad += check_field(exp_name, "data", exp_data, retire_data);
            end
            errors  <= errors + bad;
            checked <= checked + 1;
            done    <= (checked + 1 >= num_rec);
        end else if (!retire_valid && retire_we) begin
            $display("register write reported while no instruction retires, pc 0x%08h",
                     retire_pc);
            errors <= errors + 1;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    localparam int N_ENTRIES  = 28;
    localparam int RST_CYCLES = 5;
    localparam int MAX_CYCLES = RST_CYCLES + 2 * N_ENTRIES + 20; // load pass, run pass, margin

    typedef struct packed {
        logic [127:0]            name;
        logic [XLEN-1:0]         instr;
        logic                    retires; // low for instructions jumped over
        logic [XLEN-1:0]         pc;
        logic [REG_ADDR_W-1:0]   rd;
        logic                    we;
        logic [XLEN-1:0]         data;
        logic                    illegal;
    } entry_t;

    entry_t tab [N_ENTRIES];
    int     rec_map [N_ENTRIES]; // retire order to table index
    int     n_tab;
    int     n_rec;
    int     cycles;
    entry_t exp_rec;

    logic                   clk;
    logic                   rst_n;
    logic                   run;
    logic                   load_en;
    logic [IMEM_ADDR_W-1:0] load_addr;
    logic [XLEN-1:0]        load_data;
    logic                   retire_valid;
    logic [XLEN-1:0]        retire_pc;
    logic [REG_ADDR_W-1:0]  retire_rd;
    logic                   retire_we;
    logic [XLEN-1:0]        retire_data;
    logic                   retire_illegal;
    int                     checked;
    int                     errors;
    logic                   done;

    assign exp_rec = tab[rec_map[checked]];

    rv_core i_dut (
        .clk(clk), .rst_n(rst_n), .run(run), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_we(retire_we), .retire_data(retire_data),
        .retire_illegal(retire_illegal)
    );

    rv_checker i_checker (
        .clk(clk), .rst_n(rst_n), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_we(retire_we), .retire_data(retire_data),
        .retire_illegal(retire_illegal), .exp_name(exp_rec.name), .exp_pc(exp_rec.pc),
        .exp_rd(exp_rec.rd), .exp_we(exp_rec.we), .exp_data(exp_rec.data),
        .exp_illegal(exp_rec.illegal), .num_rec(n_rec), .checked(checked),
        .errors(errors), .done(done)
    );

    always #2 clk = ~clk;

    task automatic add_entry(input logic [127:0] name, input logic [XLEN-1:0] instr,
                             input logic retires, input logic [XLEN-1:0] pc,
                             input logic [REG_ADDR_W-1:0] rd, input logic we,
                             input logic [XLEN-1:0] data, input logic illegal);
        tab[n_tab] = {name, instr, retires, pc, rd, we, data, illegal};
        if (retires) begin
            rec_map[n_rec] = n_tab;
            n_rec++;
        end
        n_tab++;
    endtask

    task automatic build_table();
        add_entry("addi_neg",        32'hFFB0_0093, 1, 32'h00, 5'd1,  1, 32'hFFFF_FFFB, 0);
        add_entry("addi_pos",        32'h0030_0113, 1, 32'h04, 5'd2,  1, 32'h0000_0003, 0);
        add_entry("lui",             32'h1234_51B7, 1, 32'h08, 5'd3,  1, 32'h1234_5000, 0);
        add_entry("auipc",           32'h0000_1217, 1, 32'h0C, 5'd4,  1, 32'h0000_100C, 0);
        add_entry("addi_lui_dec",    32'hFFF1_8293, 1, 32'h10, 5'd5,  1, 32'h1234_4FFF, 0);
        add_entry("add_neg",         32'h0020_8333, 1, 32'h14, 5'd6,  1, 32'hFFFF_FFFE, 0);
        add_entry("sub_neg",         32'h4011_03B3, 1, 32'h18, 5'd7,  1, 32'h0000_0008, 0);
        add_entry("and",             32'h0020_F433, 1, 32'h1C, 5'd8,  1, 32'h0000_0003, 0);
        add_entry("or",              32'h0020_E4B3, 1, 32'h20, 5'd9,  1, 32'hFFFF_FFFB, 0);
        add_entry("xor",             32'h0020_C533, 1, 32'h24, 5'd10, 1, 32'hFFFF_FFF8, 0);
        add_entry("sll",             32'h0021_15B3, 1, 32'h28, 5'd11, 1, 32'h0000_0018, 0);
        add_entry("srl",             32'h0020_D633, 1, 32'h2C, 5'd12, 1, 32'h1FFF_FFFF, 0);
        add_entry("sra_sign",        32'h4020_D6B3, 1, 32'h30, 5'd13, 1, 32'hFFFF_FFFF, 0);
        add_entry("slt_signed",      32'h0020_A733, 1, 32'h34, 5'd14, 1, 32'h0000_0001, 0);
        add_entry("sltu_unsigned",   32'h0020_B7B3, 1, 32'h38, 5'd15, 1, 32'h0000_0000, 0);
        add_entry("addi_x0",         32'h0071_0013, 1, 32'h3C, 5'd0,  0, 32'h0000_0000, 0);
        add_entry("add_read_x0",     32'h0020_0833, 1, 32'h40, 5'd16, 1, 32'h0000_0003, 0);
        add_entry("sw_neg_offset",   32'hFE53_AE23, 1, 32'h44, 5'd0,  0, 32'h0000_0000, 0);
        add_entry("lw_after_sw",     32'h0040_2883, 1, 32'h48, 5'd17, 1, 32'h1234_4FFF, 0);
        add_entry("beq_taken",       32'h0101_0463, 1, 32'h4C, 5'd0,  0, 32'h0000_0000, 0);
        add_entry("skipped_by_beq",  32'h0010_0913, 0, 32'h50, 5'd18, 1, 32'h0000_0001, 0);
        add_entry("bne_not_taken",   32'h0101_1463, 1, 32'h54, 5'd0,  0, 32'h0000_0000, 0);
        add_entry("jal_link",        32'h00C0_09EF, 1, 32'h58, 5'd19, 1, 32'h0000_005C, 0);
        add_entry("skipped_by_jal1", 32'h0010_0A13, 0, 32'h5C, 5'd20, 1, 32'h0000_0001, 0);
        add_entry("skipped_by_jal2", 32'h0010_0A93, 0, 32'h60, 5'd21, 1, 32'h0000_0001, 0);
        add_entry("illegal_op",      32'h0000_000B, 1, 32'h64, 5'd0,  0, 32'h0000_0000, 1);
        add_entry("after_illegal",   32'h0018_8B13, 1, 32'h68, 5'd22, 1, 32'h1234_5000, 0);
        add_entry("jal_self_loop",   32'h0000_006F, 1, 32'h6C, 5'd0,  0, 32'h0000_0000, 0);
    endtask

    // run limit over reset, load and execution
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("program did not finish in time: %0d of %0d records, %0d errors",
                     checked, n_rec, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        cycles    = 0;
        n_tab     = 0;
        n_rec     = 0;
        build_table();
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_tab; i++) begin // word index follows table order
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = IMEM_ADDR_W'(i);
            load_data = tab[i].instr;
        end
        @(negedge clk);
        load_en = 1'b0;
        run     = 1'b1;
        wait (done);
        @(negedge clk);
        run = 1'b0;
        $display("checked %0d of %0d records, %0d errors", checked, n_rec, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/rv_pkg.sv
src/rv_alu.sv
src/rv_imm_gen.sv
src/rv_decoder.sv
src/rv_reg_file.sv
src/rv_data_mem.sv
src/rv_fetch.sv
src/rv_core.sv
tb/rv_checker.sv
tb/tb_rv_core.sv
